// File: sim.f
+incdir+tb
design/spi_bridge_pkg.sv
design/reg_mem.sv
design/mem_arbiter.sv
design/spi_slave.sv
design/spi_cmd_engine.sv
design/spi_mem_bridge.sv
tb/spi_mem_bridge_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the bridge testbench with Verilator, runs it and looks for the pass message
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module spi_mem_bridge_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

output=$(./obj_dir/Vspi_mem_bridge_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
   echo "Simulation ended with status $status"
   exit 1
fi

if echo "$output" | grep -q "All tests passed"; then
   exit 0
fi
exit 1

// File: tb/spi_master_tasks.svh
/* SPI master frame task and host port access task for the bridge testbench */
`ifndef SPI_MASTER_TASKS_SVH
`define SPI_MASTER_TASKS_SVH

// Mode 0, LSB first, every SCK level held for 4 clk cycles
task automatic spi_frame(input logic [31:0] tx, output logic [31:0] rx);
   int i;
   rx = '0;
   @(posedge clk);
   spi_ss   <= 1'b0;
   spi_mosi <= tx[0];
   for (i = 0; i < 32; i++) begin
      repeat (3) @(posedge clk);
      @(negedge clk);
      rx[i] = spi_miso;                      // Settled since the last synchronized fall
      @(posedge clk);
      spi_sck <= 1'b1;
      repeat (4) @(posedge clk);
      spi_sck <= 1'b0;
      if (i < 31)
         spi_mosi <= tx[i+1];
   end
   repeat (2) @(posedge clk);
   spi_ss   <= 1'b1;
   spi_mosi <= 1'b0;
   repeat (12) @(posedge clk);               // Gap lets the reply load before the next frame
endtask

task automatic host_access(input logic wr, input logic [7:0] a, input logic [15:0] d,
                           output logic [15:0] rd);
   int   n;
   logic seen;
   rd = '0;
   @(posedge clk);
   host_req   <= 1'b1;
   host_we    <= wr;
   host_addr  <= a;
   host_wdata <= d;
   n    = 0;
   seen = 1'b0;
   while (!seen && n < host_timeout) begin
      @(negedge clk);
      seen = host_gnt;
      n++;
   end
   @(posedge clk);
   host_req <= 1'b0;
   if (!seen) begin
      $display("Host grant not seen within %0d cycles", host_timeout);
      errors++;
      return;
   end
   n    = 0;
   seen = 1'b0;
   while (!seen && n < host_timeout) begin
      @(negedge clk);
      seen = host_rvalid;
      n++;
   end
   if (seen) begin
      rd = host_rdata;
   end else begin
      $display("Host read data not marked valid within %0d cycles", host_timeout);
      errors++;
   end
endtask

`endif

// File: tb/spi_mem_bridge_tb.sv
/* Testbench for the SPI register memory. Random SPI and host traffic from a
   fixed seed is checked against a reference model of the memory */
`timescale 1ns/1ns
module spi_mem_bridge_tb;

   localparam int host_timeout = 20;

   logic        clk;
   logic        reset;
   logic        spi_sck;
   logic        spi_ss;
   logic        spi_mosi;
   logic        spi_miso;
   logic        host_req;
   logic        host_we;
   logic [7:0]  host_addr;
   logic [15:0] host_wdata;
   logic        host_gnt;
   logic [15:0] host_rdata;
   logic        host_rvalid;

   logic [15:0] model [256];                 // Reference copy of the memory
   logic [7:0]  used_addrs [$];              // Addresses written so far
   int          checks;
   int          errors;
   int          first_check;
   int          first_error;

   spi_mem_bridge #(.mem_depth(256), .sync_stages(2)) u_dut (
      .clk(clk), .reset(reset),
      .spi_sck(spi_sck), .spi_ss(spi_ss), .spi_mosi(spi_mosi), .spi_miso(spi_miso),
      .host_req(host_req), .host_we(host_we), .host_addr(host_addr),
      .host_wdata(host_wdata), .host_gnt(host_gnt), .host_rdata(host_rdata),
      .host_rvalid(host_rvalid)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   `include "spi_master_tasks.svh"

   task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      assert (got === exp) else begin
         $display("FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp);
         errors++;
      end
   endtask

   task automatic check_reply(input logic [31:0] reply, input logic done, input logic wr,
                              input logic ill, input logic [7:0] a, input logic [15:0] d);
      spi_bridge_pkg::ctl_byte_u st;
      st = reply[7:0];
      check_val("status.done", 32'(st.status.done), 32'(done));
      check_val("status.was_write", 32'(st.status.was_write), 32'(wr));
      check_val("status.illegal", 32'(st.status.illegal), 32'(ill));
      check_val("reply address", 32'(reply[15:8]), 32'(a));
      check_val("reply data", 32'(reply[31:16]), 32'(d));
   endtask

   // The reply to a command comes back during the nop frame that follows it
   task automatic spi_cmd(input logic [7:0] op, input logic [7:0] a, input logic [15:0] d,
                          output logic [31:0] reply);
      logic [31:0] stale;
      spi_frame({d, a, op}, stale);
      spi_frame({16'h0000, 8'h00, spi_bridge_pkg::op_nop}, reply);
   endtask

   task automatic spi_write(input logic [7:0] a, input logic [15:0] d);
      logic [31:0] reply;
      spi_cmd(spi_bridge_pkg::op_write, a, d, reply);
      check_reply(reply, 1'b1, 1'b1, 1'b0, a, d);
      model[a] = d;
      used_addrs.push_back(a);
   endtask

   task automatic spi_read(input logic [7:0] a);
      logic [31:0] reply;
      spi_cmd(spi_bridge_pkg::op_read, a, 16'($urandom()), reply);
      check_reply(reply, 1'b1, 1'b0, 1'b0, a, model[a]);
   endtask

   // A write access returns the stored word on host_rdata as well
   task automatic host_write(input logic [7:0] a, input logic [15:0] d);
      logic [15:0] rd;
      host_access(1'b1, a, d, rd);
      model[a] = d;
      used_addrs.push_back(a);
      check_val("host_rdata", 32'(rd), 32'(d));
   endtask

   task automatic host_read(input logic [7:0] a);
      logic [15:0] rd;
      host_access(1'b0, a, 16'h0000, rd);
      check_val("host_rdata", 32'(rd), 32'(model[a]));
   endtask

   function automatic logic [7:0] pick_addr();
      return used_addrs[$urandom_range(used_addrs.size() - 1, 0)];
   endfunction

   task automatic begin_test();
      first_check = checks;
      first_error = errors;
   endtask

   task automatic end_test(input string name);
      $display("%s: %0d checks, %0d errors", name, checks - first_check, errors - first_error);
   endtask

   initial begin
      logic [7:0]                a;
      logic [7:0]                ha;
      logic [31:0]               reply;
      logic [4:0]                count_exp;
      logic                      spi_busy;
      int                        rounds;
      spi_bridge_pkg::ctl_byte_u st;
      void'($urandom(80674));
      checks      = 0;
      errors      = 0;
      reset      <= 1'b1;
      spi_sck    <= 1'b0;
      spi_ss     <= 1'b1;
      spi_mosi   <= 1'b0;
      host_req   <= 1'b0;
      host_we    <= 1'b0;
      host_addr  <= 8'h00;
      host_wdata <= 16'h0000;
      repeat (4) @(posedge clk);
      reset <= 1'b0;

      begin_test();
      @(negedge clk);
      check_val("spi_miso", 32'(spi_miso), 32'h0);
      check_val("host_gnt", 32'(host_gnt), 32'h0);
      check_val("host_rvalid", 32'(host_rvalid), 32'h0);
      end_test("Reset state");

      begin_test();
      repeat (40) begin
         spi_write(8'($urandom()), 16'($urandom()));
         spi_read(pick_addr());
      end
      end_test("SPI write then read");

      begin_test();
      repeat (20) begin
         a = 8'($urandom());
         host_write(a, 16'($urandom()));
         spi_read(a);
         a = 8'($urandom());
         spi_write(a, 16'($urandom()));
         host_read(a);
      end
      end_test("Host port");

      // SPI keeps to the lower half and the host to the upper half of the memory
      begin_test();
      repeat (6) begin
         spi_busy = 1'b1;
         rounds   = 0;
         fork
            begin
               a = {1'b0, 7'($urandom())};
               spi_write(a, 16'($urandom()));
               spi_read(a);
               spi_busy = 1'b0;
            end
            while (spi_busy && rounds < 400) begin
               ha = {1'b1, 7'($urandom())};
               host_write(ha, 16'($urandom()));
               host_read(ha);
               rounds++;
            end
         join
      end
      end_test("Contention");

      begin_test();
      repeat (10) begin
         a = pick_addr();
         spi_cmd(8'($urandom_range(255, 3)), a, 16'($urandom()), reply);
         check_reply(reply, 1'b0, 1'b0, 1'b1, a, 16'h0000);
         spi_read(a);
      end
      end_test("Illegal opcode");

      begin_test();
      spi_frame({16'h0000, 8'h00, spi_bridge_pkg::op_nop}, reply);
      st = reply[7:0];
      repeat (40) begin
         count_exp = st.status.count + 5'd1;
         spi_frame({16'h0000, pick_addr(), spi_bridge_pkg::op_read}, reply);
         st = reply[7:0];
         check_val("status.count", 32'(st.status.count), 32'(count_exp));
      end
      end_test("Frame counter");

      $display("Total: %0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

// File: design/spi_mem_bridge.sv
/* SPI register memory. An SPI slave and a local host port share one
   word memory through a round-robin arbiter */
`timescale 1ns/1ns
module spi_mem_bridge #(
   parameter int mem_depth   = 256,
   parameter int sync_stages = 2
) (
   input  logic                                  clk,
   input  logic                                  reset,
   input  logic                                  spi_sck,
   input  logic                                  spi_ss,
   input  logic                                  spi_mosi,
   output logic                                  spi_miso,
   input  logic                                  host_req,
   input  logic                                  host_we,
   input  logic [spi_bridge_pkg::addr_width-1:0] host_addr,
   input  logic [spi_bridge_pkg::data_width-1:0] host_wdata,
   output logic                                  host_gnt,
   output logic [spi_bridge_pkg::data_width-1:0] host_rdata,
   output logic                                  host_rvalid
);

   logic                                   frame_valid;
   logic [spi_bridge_pkg::frame_width-1:0] frame_word;
   logic                                   reply_load;
   logic [spi_bridge_pkg::frame_width-1:0] reply_word;
   logic                                   spi_req;
   logic                                   spi_we;
   logic [spi_bridge_pkg::addr_width-1:0]  spi_addr;
   logic [spi_bridge_pkg::data_width-1:0]  spi_wdata;
   logic                                   spi_gnt;
   logic [spi_bridge_pkg::data_width-1:0]  spi_rdata;
   logic                                   mem_en;
   logic                                   mem_we;
   logic [spi_bridge_pkg::addr_width-1:0]  mem_addr;
   logic [spi_bridge_pkg::data_width-1:0]  mem_wdata;
   logic [spi_bridge_pkg::data_width-1:0]  mem_rdata;

   spi_slave #(.sync_stages(sync_stages)) u_slave (
      .clk(clk), .reset(reset),
      .spi_sck(spi_sck), .spi_ss(spi_ss), .spi_mosi(spi_mosi), .spi_miso(spi_miso),
      .reply_load(reply_load), .reply_word(reply_word),
      .frame_valid(frame_valid), .frame_word(frame_word)
   );

   spi_cmd_engine u_engine (
      .clk(clk), .reset(reset),
      .frame_valid(frame_valid), .frame_word(frame_word),
      .req(spi_req), .we(spi_we), .addr(spi_addr), .wdata(spi_wdata),
      .gnt(spi_gnt), .rdata(spi_rdata),
      .reply_load(reply_load), .reply_word(reply_word)
   );

   mem_arbiter u_arbiter (
      .clk(clk), .reset(reset),
      .spi_req(spi_req), .spi_we(spi_we), .spi_addr(spi_addr), .spi_wdata(spi_wdata),
      .spi_gnt(spi_gnt), .spi_rdata(spi_rdata),
      .host_req(host_req), .host_we(host_we), .host_addr(host_addr),
      .host_wdata(host_wdata), .host_gnt(host_gnt), .host_rdata(host_rdata),
      .host_rvalid(host_rvalid),
      .mem_en(mem_en), .mem_we(mem_we), .mem_addr(mem_addr),
      .mem_wdata(mem_wdata), .mem_rdata(mem_rdata)
   );

   reg_mem #(.mem_depth(mem_depth)) u_mem (
      .clk(clk),
      .mem_en(mem_en), .mem_we(mem_we), .mem_addr(mem_addr),
      .mem_wdata(mem_wdata), .mem_rdata(mem_rdata)
   );

endmodule

// File: design/spi_cmd_engine.sv
/* Command engine. Decodes each SPI frame, runs the memory read or write
   through the arbiter and builds the status reply for the next frame */
`timescale 1ns/1ns
module spi_cmd_engine (
   input  logic                                   clk,
   input  logic                                   reset,
   input  logic                                   frame_valid,
   input  logic [spi_bridge_pkg::frame_width-1:0] frame_word,
   output logic                                   req,
   output logic                                   we,
   output logic [spi_bridge_pkg::addr_width-1:0]  addr,
   output logic [spi_bridge_pkg::data_width-1:0]  wdata,
   input  logic                                   gnt,
   input  logic [spi_bridge_pkg::data_width-1:0]  rdata,
   output logic                                   reply_load,
   output logic [spi_bridge_pkg::frame_width-1:0] reply_word
);

   localparam logic [1:0] st_idle  = 2'd0;
   localparam logic [1:0] st_grant = 2'd1;
   localparam logic [1:0] st_rdata = 2'd2;

   spi_bridge_pkg::ctl_byte_u                 cmd_byte;
   spi_bridge_pkg::ctl_byte_u                 status_byte;
   logic [1:0]                                state;
   logic [4:0]                                frame_cnt;
   logic [4:0]                                cnt_next;
   logic                                      is_read;
   logic                                      is_write;
   logic                                      is_nop;
   logic                                      load_next;
   logic [spi_bridge_pkg::addr_width-1:0]     frame_addr;
   logic [spi_bridge_pkg::data_width-1:0]     frame_data;
   logic [spi_bridge_pkg::addr_width-1:0]     reply_addr;
   logic [spi_bridge_pkg::data_width-1:0]     reply_data;

   assign cmd_byte   = frame_word[7:0];
   assign frame_addr = frame_word[8 +: spi_bridge_pkg::addr_width];
   assign frame_data = frame_word[8+spi_bridge_pkg::addr_width +: spi_bridge_pkg::data_width];
   assign is_read    = (cmd_byte.opcode == spi_bridge_pkg::op_read);
   assign is_write   = (cmd_byte.opcode == spi_bridge_pkg::op_write);
   assign is_nop     = (cmd_byte.opcode == spi_bridge_pkg::op_nop);
   assign cnt_next   = frame_cnt + 5'd1;

   // Frames without a memory access are answered right away
   assign load_next = (state == st_idle && frame_valid && !is_read && !is_write) ||
                      (state == st_grant && gnt && we) ||
                      (state == st_rdata);

   assign reply_addr = (state == st_idle) ? frame_addr : addr;
   assign reply_data = (state == st_rdata) ? rdata :
                       (state == st_grant) ? wdata : '0;

   always_comb begin
      status_byte.status.done      = 1'b1;
      status_byte.status.was_write = we;
      status_byte.status.illegal   = 1'b0;
      status_byte.status.count     = frame_cnt;
      if (state == st_idle) begin
         status_byte.status.done      = is_nop;
         status_byte.status.was_write = 1'b0;
         status_byte.status.illegal   = !is_nop;
         status_byte.status.count     = cnt_next;   // Counter updates on this same edge
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state      <= st_idle;
         req        <= 1'b0;
         reply_load <= 1'b0;
         frame_cnt  <= '0;
      end else begin
         reply_load <= load_next;
         case (state)
            st_idle: begin
               if (frame_valid) begin
                  frame_cnt <= cnt_next;
                  if (is_read || is_write) begin
                     req   <= 1'b1;
                     state <= st_grant;
                  end
               end
            end
            st_grant: begin
               if (gnt) begin
                  req   <= 1'b0;
                  state <= we ? st_idle : st_rdata;
               end
            end
            default: state <= st_idle;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == st_idle && frame_valid) begin
         we    <= is_write;
         addr  <= frame_addr;
         wdata <= frame_data;
      end
      if (load_next) begin
         reply_word <= {reply_data, reply_addr, status_byte};
      end
   end

   req_held: assert property (@(posedge clk) disable iff (reset)
      $rose(req) |=> req ##1 (gnt || $past(gnt)))
      else $error("Request not held until a grant within two cycles");

   no_overrun: assert property (@(posedge clk) disable iff (reset)
      frame_valid |-> state == st_idle)
      else $error("SPI frame arrived while a command was still running");

endmodule

// File: design/spi_slave.sv
/* SPI slave in mode 0. Shifts 32-bit frames in on MOSI, LSB first, and
   sends the reply loaded by the command engine out on MISO in the next frame */
`timescale 1ns/1ns
module spi_slave #(
   parameter int sync_stages = 2
) (
   input  logic                                   clk,
   input  logic                                   reset,
   input  logic                                   spi_sck,
   input  logic                                   spi_ss,
   input  logic                                   spi_mosi,
   output logic                                   spi_miso,
   input  logic                                   reply_load,
   input  logic [spi_bridge_pkg::frame_width-1:0] reply_word,
   output logic                                   frame_valid,
   output logic [spi_bridge_pkg::frame_width-1:0] frame_word
);

   logic [sync_stages-1:0] sck_sync;
   logic [sync_stages-1:0] ss_sync;
   logic [sync_stages-1:0] mosi_sync;
   logic                   sck_d;
   logic                   ss_d;
   logic                   sck_rise;
   logic                   sck_fall;
   logic                   ss_rise;
   logic                   ss_fall;
   logic                   bit_take;
   logic                   last_bit;
   logic [4:0]             bit_cnt;
   logic [spi_bridge_pkg::frame_width-1:0] rx_shift;
   logic [spi_bridge_pkg::frame_width-1:0] tx_shift;
   logic [spi_bridge_pkg::frame_width-1:0] reply_hold;

   assign sck_rise = sck_sync[sync_stages-1] & ~sck_d;
   assign sck_fall = ~sck_sync[sync_stages-1] & sck_d;
   assign ss_rise  = ss_sync[sync_stages-1] & ~ss_d;
   assign ss_fall  = ~ss_sync[sync_stages-1] & ss_d;
   assign bit_take = sck_rise & ~ss_d & ~ss_rise;
   assign last_bit = bit_take & (bit_cnt == 5'd31);

   assign spi_miso = tx_shift[0] & ~ss_d;   // Held low outside a frame

   always_ff @(posedge clk) begin
      if (reset) begin
         sck_sync  <= '0;
         ss_sync   <= '1;                    // Idle bus has SS high
         mosi_sync <= '0;
         sck_d     <= 1'b0;
         ss_d      <= 1'b1;
      end else begin
         sck_sync  <= {sck_sync[sync_stages-2:0], spi_sck};
         ss_sync   <= {ss_sync[sync_stages-2:0], spi_ss};
         mosi_sync <= {mosi_sync[sync_stages-2:0], spi_mosi};
         sck_d     <= sck_sync[sync_stages-1];
         ss_d      <= ss_sync[sync_stages-1];
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         bit_cnt     <= '0;
         frame_valid <= 1'b0;
      end else begin
         frame_valid <= last_bit;
         if (ss_fall || ss_rise) begin
            bit_cnt <= '0;
         end else if (bit_take) begin
            bit_cnt <= bit_cnt + 5'd1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (bit_take) begin
         rx_shift <= {mosi_sync[sync_stages-1], rx_shift[spi_bridge_pkg::frame_width-1:1]};
      end
      if (last_bit) begin
         frame_word <= {mosi_sync[sync_stages-1], rx_shift[spi_bridge_pkg::frame_width-1:1]};
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         reply_hold <= '0;
      end else if (reply_load) begin
         reply_hold <= reply_word;
      end
   end

   // Bit 0 of the reply is on MISO before the first SCK edge of the frame
   always_ff @(posedge clk) begin
      if (ss_fall) begin
         tx_shift <= reply_hold;
      end else if (sck_fall && !ss_d) begin
         tx_shift <= {1'b0, tx_shift[spi_bridge_pkg::frame_width-1:1]};
      end
   end

   frame_in_window: assert property (@(posedge clk) disable iff (reset)
      frame_valid |-> !ss_sync[sync_stages-1])
      else $error("Frame strobe outside an SS window");

endmodule

// File: design/mem_arbiter.sv
/* Round-robin arbiter that puts the SPI command engine and the host port
   onto one memory port and routes read data back */
`timescale 1ns/1ns
module mem_arbiter (
   input  logic                                  clk,
   input  logic                                  reset,
   input  logic                                  spi_req,
   input  logic                                  spi_we,
   input  logic [spi_bridge_pkg::addr_width-1:0] spi_addr,
   input  logic [spi_bridge_pkg::data_width-1:0] spi_wdata,
   output logic                                  spi_gnt,
   output logic [spi_bridge_pkg::data_width-1:0] spi_rdata,
   input  logic                                  host_req,
   input  logic                                  host_we,
   input  logic [spi_bridge_pkg::addr_width-1:0] host_addr,
   input  logic [spi_bridge_pkg::data_width-1:0] host_wdata,
   output logic                                  host_gnt,
   output logic [spi_bridge_pkg::data_width-1:0] host_rdata,
   output logic                                  host_rvalid,
   output logic                                  mem_en,
   output logic                                  mem_we,
   output logic [spi_bridge_pkg::addr_width-1:0] mem_addr,
   output logic [spi_bridge_pkg::data_width-1:0] mem_wdata,
   input  logic [spi_bridge_pkg::data_width-1:0] mem_rdata
);

   logic last_host;
   logic spi_elig;
   logic host_elig;
   logic pick_spi;
   logic pick_host;

   // A side holding its grant is not eligible again until it drops req
   assign spi_elig  = spi_req & ~spi_gnt;
   assign host_elig = host_req & ~host_gnt;
   assign pick_spi  = spi_elig & (~host_elig | last_host);
   assign pick_host = host_elig & ~pick_spi;

   always_ff @(posedge clk) begin
      if (reset) begin
         spi_gnt     <= 1'b0;
         host_gnt    <= 1'b0;
         host_rvalid <= 1'b0;
         last_host   <= 1'b0;
      end else begin
         spi_gnt     <= pick_spi;
         host_gnt    <= pick_host;
         host_rvalid <= host_gnt;           // Memory answers one cycle after the grant
         if (pick_spi || pick_host) begin
            last_host <= pick_host;
         end
      end
   end

   assign mem_en    = spi_gnt | host_gnt;
   assign mem_we    = spi_gnt ? spi_we : (host_gnt & host_we);
   assign mem_addr  = spi_gnt ? spi_addr : host_addr;
   assign mem_wdata = spi_gnt ? spi_wdata : host_wdata;

   assign spi_rdata  = mem_rdata;
   assign host_rdata = mem_rdata;

   one_grant: assert property (@(posedge clk) disable iff (reset)
      !(spi_gnt && host_gnt))
      else $error("Both sides granted in one cycle");

   spi_gnt_req: assert property (@(posedge clk) disable iff (reset)
      spi_gnt |-> spi_req)
      else $error("SPI grant without a request");

   host_gnt_req: assert property (@(posedge clk) disable iff (reset)
      host_gnt |-> host_req)
      else $error("Host grant without a request");

endmodule

// File: design/reg_mem.sv
/* Single-port synchronous word memory with one cycle of read latency */
`timescale 1ns/1ns
module reg_mem #(
   parameter int mem_depth = 256
) (
   input  logic                                  clk,
   input  logic                                  mem_en,
   input  logic                                  mem_we,
   input  logic [spi_bridge_pkg::addr_width-1:0] mem_addr,
   input  logic [spi_bridge_pkg::data_width-1:0] mem_wdata,
   output logic [spi_bridge_pkg::data_width-1:0] mem_rdata
);

   logic [spi_bridge_pkg::data_width-1:0] mem [mem_depth];

   // A write also returns the new word, so a write access reads back what it stored
   always_ff @(posedge clk) begin
      if (mem_en) begin
         if (mem_we) begin
            mem[mem_addr] <= mem_wdata;
            mem_rdata     <= mem_wdata;
         end else begin
            mem_rdata <= mem[mem_addr];
         end
      end
   end

   addr_in_range: assert property (@(posedge clk)
      mem_en |-> (int'(mem_addr) < mem_depth))
      else $error("Memory access beyond the configured depth");

endmodule

// File: design/spi_bridge_pkg.sv
/* SPI memory bridge shared definitions: frame field widths, opcodes and
   the control byte that is read as a command and written back as status */
package spi_bridge_pkg;

   localparam int addr_width  = 8;
   localparam int data_width  = 16;
   localparam int frame_width = 32;

   // Frame layout, LSB first on the wire
   // [31:16] data, [15:8] address, [7:0] opcode inbound or status outbound

   localparam logic [7:0] op_nop   = 8'h00;
   localparam logic [7:0] op_read  = 8'h01;
   localparam logic [7:0] op_write = 8'h02;

   typedef union packed {
      logic [7:0] opcode;             // Command view of an inbound frame
      struct packed {
         logic [4:0] count;           // Frame counter, wraps at 32
         logic       illegal;         // Opcode was not recognized
         logic       was_write;       // Previous command wrote memory
         logic       done;            // Previous command was executed
      } status;                       // Status view of an outbound frame
   } ctl_byte_u;

endpackage
